/* vlog.f */
+incdir+.
lmk_cfg_pkg.sv
bit_tick_gen.sv
lmk_sequence_rom.sv
spi_frame_tx.sv
config_sequencer.sv
lmk04906_config_top.sv
tb_clock_gen.sv
lmk_cfg_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module lmk_cfg_tb -o lmk_cfg_sim
	out="$$(./obj_dir/lmk_cfg_sim)"; echo "$$out"; echo "$$out" | grep -q '^No errors$$'

clean:
	rm -rf obj_dir

/* lmk_cfg_tb.sv */
// testbench for the LMK04906 configurator decoding the serial bus against expected word lists
`include "lmk_cfg_macros.svh"

module lmk_cfg_tb;

   localparam logic [4:0] N_FRAMES = 5'd26;   // register words per run
   localparam logic [2:0] N_ROWS   = 3'd5;
   localparam int PAUSE_PERIODS = 25000;   // bit periods per power-up pause
   localparam int MIN_GAP    = PAUSE_PERIODS * `LMK_SPI_DIV;   // clk50 cycles
   // 26 frames of about 40 periods plus four pauses
   localparam int RUN_CYCLES = (26 * 40 + 4 * (PAUSE_PERIODS + 3)) * `LMK_SPI_DIV;
   localparam int WATCHDOG   = 5 * (RUN_CYCLES + 1100) * 10 * 2;

   typedef struct packed
   {
      logic [`LMK_SEL_W-1:0] sel;
      logic [4:0]            frames;   // frames expected before config_done
   } stim_row_t;

   logic                  clk50;
   logic                  rst_n;
   logic [`LMK_SEL_W-1:0] freq_select;
   logic                  lmk_clk;
   logic                  lmk_data;
   logic                  lmk_le;
   logic                  config_done;

   stim_row_t   stim_table [N_ROWS];
   logic [31:0] exp_words  [N_FRAMES];
   logic        gap_before [N_FRAMES];   // frame follows a power-up pause
   integer      seed;

   // bus decoder state
   int          cycle = 0;
   int          last_le_rise;
   logic [4:0]  frame_idx;
   logic [5:0]  bit_cnt;
   logic [31:0] shift;
   logic        prev_le;
   logic        prev_clk;
   logic        prev_done;

   tb_clock_gen #(.PERIOD(10)) clk_src (.clk(clk50));

   lmk04906_config_top dut0
   (
      .clk50       (clk50),
      .rst_n       (rst_n),
      .freq_select (freq_select),
      .lmk_clk     (lmk_clk),
      .lmk_data    (lmk_data),
      .lmk_le      (lmk_le),
      .config_done (config_done)
   );

   //////////////////////////////////////////////////
   // expected register words

   // all outputs at 322.265625 MHz
   function automatic logic [31:0] base_word(input int idx);
      case (idx)
         1:  return 32'h8016_0200;
         3:  return 32'h2014_0100;
         5:  return 32'h1014_0101;
         6:  return 32'hA014_0082;
         7:  return 32'h0014_0103;
         8:  return 32'h0014_0104;
         9:  return 32'h8014_0C85;
         10: return 32'h0114_0006;
         11: return 32'h0111_0007;
         12: return 32'h0001_0008;
         13: return 32'h5555_5549;
         14: return 32'h9002_410A;
         15: return 32'h3401_100B;
         16: return 32'h130C_006C;
         17: return 32'h3B02_820D;
         18: return 32'h0200_000E;
         19: return 32'h8000_800F;
         20: return 32'hC155_0410;
         21: return 32'h0000_00D8;
         22: return 32'h02C9_C419;
         23: return 32'h8FA8_001A;
         24: return 32'h1000_0F3B;
         25: return 32'h0080_031C;
         26: return 32'h0080_227D;
         27: return 32'h0300_227E;
         28: return 32'h001F_001F;
         default: return 32'h0;
      endcase
   endfunction

   // 644.53125 MHz halves the channel divider in bits 15:5
   function automatic logic [31:0] fast_word(input logic [31:0] w);
      return {w[31:16], 1'b0, w[15:6], w[4:0]};
   endfunction

   task automatic build_expected(input logic [`LMK_SEL_W-1:0] sel);
      logic [4:0]  n;
      logic        pend;
      logic [31:0] w;
      n    = 5'd0;
      pend = 1'b0;
      for (int i = 0; i < `LMK_LUT_SIZE; i++)
      begin
         if (i inside {0, 2, 4, 29})
            pend = 1'b1;   // pause entry sends no frame
         else
         begin
            w = base_word(i);
            if ((i == 3 && sel[3]) || (i == 5 && sel[2]) || (i == 7 && sel[1]) ||
                (i == 8 && sel[0]))
               w = fast_word(w);
            exp_words[n]  = w;
            gap_before[n] = pend;
            pend          = 1'b0;
            n             = n + 5'd1;
         end
      end
   endtask

   //////////////////////////////////////////////////
   // error reporting

   task automatic abort_run();
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      abort_run();
   endtask

   task automatic report_failure(input string msg);
      $display("FAILURE at %0t: %s", $time, msg);
      abort_run();
   endtask

   //////////////////////////////////////////////////
   // serial bus decoder on values settled from the previous cycle

   always @(posedge clk50)
   begin
      cycle = cycle + 1;
      if (!rst_n)
      begin
         frame_idx    = 5'd0;
         bit_cnt      = 6'd0;
         shift        = 32'h0;
         last_le_rise = cycle;   // pause 0 counts from reset
         prev_le      = 1'b1;
         prev_clk     = 1'b0;
         prev_done    = 1'b0;
      end
      else
      begin
         if (prev_le && !lmk_le)
         begin
            assert (frame_idx < N_FRAMES)
               else report_failure("lmk_le fell after the last expected frame");
            if (gap_before[frame_idx])
               assert (cycle - last_le_rise >= MIN_GAP)
                  else report_mismatch("frame gap cycles", MIN_GAP, cycle - last_le_rise);
            bit_cnt = 6'd0;
            shift   = 32'h0;
         end
         if (!prev_clk && lmk_clk)
         begin
            assert (!lmk_le) else report_failure("lmk_clk rose while lmk_le was high");
            shift   = {shift[30:0], lmk_data};   // MSB first
            bit_cnt = bit_cnt + 6'd1;
         end
         if (!prev_le && lmk_le)
         begin
            assert (bit_cnt == 6'd32)
               else report_mismatch("lmk_clk edges", 32'd32, 32'(bit_cnt));
            assert (shift == exp_words[frame_idx])
               else report_mismatch("lmk_data word", exp_words[frame_idx], shift);
            frame_idx    = frame_idx + 5'd1;
            last_le_rise = cycle;
         end
         if (!prev_done && config_done)
            assert (frame_idx == N_FRAMES && lmk_le)
               else report_failure("config_done rose before the last frame closed");
         prev_le   = lmk_le;
         prev_clk  = lmk_clk;
         prev_done = config_done;
      end
   end

   //////////////////////////////////////////////////
   // stimulus table with one run per row

   initial
   begin
      logic [2:0] r;
      int         wait_cnt;
      rst_n       = 1'b0;
      freq_select = '0;
      seed        = 32'h1e90dd2a;
      stim_table[0] = '{sel: 4'h0, frames: N_FRAMES};
      stim_table[1] = '{sel: 4'hF, frames: N_FRAMES};
      stim_table[2] = '{sel: 4'h8, frames: N_FRAMES};
      stim_table[3] = '{sel: 4'h5, frames: N_FRAMES};
      stim_table[4] = '{sel: `LMK_SEL_W'($random(seed)), frames: N_FRAMES};
      for (r = 3'd0; r < N_ROWS; r = r + 3'd1)
      begin
         @(negedge clk50);
         rst_n       = 1'b0;
         freq_select = stim_table[r].sel;
         build_expected(stim_table[r].sel);
         repeat (10) @(negedge clk50);
         assert (lmk_le === 1'b1) else report_mismatch("lmk_le", 32'd1, 32'(lmk_le));
         assert (lmk_clk === 1'b0) else report_mismatch("lmk_clk", 32'd0, 32'(lmk_clk));
         assert (config_done === 1'b0)
            else report_mismatch("config_done", 32'd0, 32'(config_done));
         rst_n    = 1'b1;
         wait_cnt = 0;
         while (config_done !== 1'b1 && wait_cnt < 2 * RUN_CYCLES)
         begin
            @(negedge clk50);
            wait_cnt++;
         end
         assert (config_done === 1'b1)
            else report_failure("config_done did not rise within the expected run length");
         assert (frame_idx == stim_table[r].frames)
            else report_mismatch("frame count", 32'(stim_table[r].frames), 32'(frame_idx));
         repeat (1000)
         begin
            @(negedge clk50);
            assert (config_done === 1'b1)
               else report_mismatch("config_done", 32'd1, 32'(config_done));
            assert (lmk_le === 1'b1) else report_mismatch("lmk_le", 32'd1, 32'(lmk_le));
         end
         $display("select %h: %0d frames matched", stim_table[r].sel, frame_idx);
      end
      $display("No errors");
      $finish;
   end

   // watchdog covering five runs with margin
   initial
   begin
      #(WATCHDOG);
      report_failure("watchdog timeout, the run did not finish in time");
   end

endmodule

/* tb_clock_gen.sv */
// testbench clock source, free-running square wave
module tb_clock_gen
#(
   parameter int PERIOD = 10
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD / 2) clk = ~clk;   // half period per phase
   end

endmodule

/* lmk04906_config_top.sv */
// LMK04906 power-up configurator top level
`include "lmk_cfg_macros.svh"

module lmk04906_config_top
(
   input  logic                 clk50,
   input  logic                 rst_n,
   input  logic [`LMK_SEL_W-1:0] freq_select,   // hold stable during a run
   output logic                 lmk_clk,
   output logic                 lmk_data,
   output logic                 lmk_le,
   output logic                 config_done
);
   import lmk_cfg_pkg::*;

   logic                  bit_rise;
   logic                  bit_fall;
   logic [`LMK_IDX_W-1:0] index;
   lmk_entry_t            entry;
   logic                  frame_start;
   lmk_reg_word_t         frame_word;
   logic                  frame_done;

   //////////////////////////////////////////////////
   // divider, table, FSM, framer

   bit_tick_gen u_tick
   (
      .clk50    (clk50),
      .rst_n    (rst_n),
      .bit_rise (bit_rise),
      .bit_fall (bit_fall)
   );

   lmk_sequence_rom u_rom
   (
      .index       (index),
      .freq_select (freq_select),
      .entry       (entry)
   );

   config_sequencer u_seq
   (
      .clk50       (clk50),
      .rst_n       (rst_n),
      .bit_fall    (bit_fall),
      .entry       (entry),
      .frame_done  (frame_done),
      .index       (index),
      .frame_start (frame_start),
      .frame_word  (frame_word),
      .config_done (config_done)
   );

   spi_frame_tx u_tx
   (
      .clk50       (clk50),
      .rst_n       (rst_n),
      .bit_rise    (bit_rise),
      .bit_fall    (bit_fall),
      .frame_start (frame_start),
      .frame_word  (frame_word),
      .frame_done  (frame_done),
      .lmk_clk     (lmk_clk),
      .lmk_data    (lmk_data),
      .lmk_le      (lmk_le)
   );

endmodule

/* config_sequencer.sv */
// LMK04906 sequence walker running pauses, launching frames and flagging completion
`include "lmk_cfg_macros.svh"

module config_sequencer
(
   input  logic                       clk50,
   input  logic                       rst_n,
   input  logic                       bit_fall,
   input  lmk_cfg_pkg::lmk_entry_t    entry,
   input  logic                       frame_done,
   output logic [`LMK_IDX_W-1:0]      index,
   output logic                       frame_start,
   output lmk_cfg_pkg::lmk_reg_word_t frame_word,
   output logic                       config_done
);
   import lmk_cfg_pkg::*;

   localparam logic [`LMK_IDX_W-1:0] LAST_IDX = `LMK_IDX_W'(`LMK_LUT_SIZE - 1);

   seq_state_t             state;
   logic [`LMK_WORD_W-1:0] delay_cnt;

   // launch lines up with the bit_fall that the transmitter starts on
   assign frame_start = bit_fall && (state == fetch) && !entry.is_delay && !config_done;
   assign frame_word  = entry.payload.reg_word;

   //////////////////////////////////////////////////
   // sequence FSM, one step per bit period

   always_ff @(posedge clk50 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state       <= fetch;
         index       <= '0;
         delay_cnt   <= '0;
         config_done <= 1'b0;
      end
      else if (bit_fall && !config_done)
      begin
         case (state)
            fetch:
            begin
               delay_cnt <= '0;
               if (entry.is_delay)
                  state <= pause;
               else
                  state <= send;    // frame_start goes out this cycle
            end

            pause:
            begin
               // lasts delay_count + 1 bit periods
               if (delay_cnt == entry.payload.delay_count)
                  state <= advance;
               else
                  delay_cnt <= delay_cnt + 1'b1;
            end

            send:
            begin
               if (frame_done)
                  state <= advance;
            end

            advance:
            begin
               index <= index + 1'b1;
               if (index == LAST_IDX)
                  config_done <= 1'b1;   // held until reset
               state <= fetch;
            end

            default:
            begin
               state <= fetch;
            end
         endcase
      end
   end

endmodule

/* spi_frame_tx.sv */
// three-wire serial framer shifting one LMK04906 register word out MSB first
`include "lmk_cfg_macros.svh"

module spi_frame_tx
(
   input  logic                       clk50,
   input  logic                       rst_n,
   input  logic                       bit_rise,
   input  logic                       bit_fall,
   input  logic                       frame_start,
   input  lmk_cfg_pkg::lmk_reg_word_t frame_word,
   output logic                       frame_done,
   output logic                       lmk_clk,
   output logic                       lmk_data,
   output logic                       lmk_le
);
   import lmk_cfg_pkg::*;

   localparam int TICK_W = $clog2(`LMK_T_FRAME_END + 1);
   localparam logic [TICK_W-1:0] T_LE_START  = TICK_W'(`LMK_T_LE_START);
   localparam logic [TICK_W-1:0] T_CLK_START = TICK_W'(`LMK_T_CLK_START);
   localparam logic [TICK_W-1:0] T_CLK_END   = TICK_W'(`LMK_T_CLK_END);
   localparam logic [TICK_W-1:0] T_LE_END    = TICK_W'(`LMK_T_LE_END);
   localparam logic [TICK_W-1:0] T_FRAME_END = TICK_W'(`LMK_T_FRAME_END);
   localparam logic [TICK_W-1:0] T_LOAD      = TICK_W'(`LMK_T_CLK_START - 1);

   logic                   busy;
   logic [TICK_W-1:0]      tick;       // bit period within the frame
   logic [TICK_W-1:0]      tick_nx;
   logic                   le_window;
   logic                   clk_window;
   lmk_reg_word_t          word_q;
   logic [`LMK_WORD_W-1:0] shreg;

   assign tick_nx    = tick + 1'b1;
   assign le_window  = busy && (tick_nx >= T_LE_START) && (tick_nx <= T_LE_END);
   assign clk_window = busy && (tick >= T_CLK_START) && (tick <= T_CLK_END);
   assign frame_done = busy && bit_fall && (tick == T_FRAME_END);
   assign lmk_data   = shreg[`LMK_WORD_W-1];

   //////////////////////////////////////////////////
   // frame tick counter

   always_ff @(posedge clk50 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy <= 1'b0;
         tick <= '0;
      end
      else if (frame_start)
      begin
         busy <= 1'b1;
         tick <= '0;
      end
      else if (busy && bit_fall)
      begin
         if (tick == T_FRAME_END)
            busy <= 1'b0;
         tick <= tick_nx;
      end
   end

   always_ff @(posedge clk50)
   begin
      if (frame_start)
         word_q <= frame_word;   // held for the whole frame
   end

   // data moves on bit_fall so it is settled at each lmk_clk rise
   always_ff @(posedge clk50 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         shreg <= '0;
      end
      else if (busy && bit_fall)
      begin
         if (tick == T_LOAD)
            shreg <= word_q;
         else
            shreg <= {shreg[`LMK_WORD_W-2:0], 1'b0};
      end
   end

   //////////////////////////////////////////////////
   // registered bus strobes

   always_ff @(posedge clk50 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         lmk_clk <= 1'b0;
         lmk_le  <= 1'b1;
      end
      else
      begin
         if (bit_rise && clk_window)
            lmk_clk <= 1'b1;     // high half of the period
         else if (bit_fall)
            lmk_clk <= 1'b0;
         if (bit_fall)
            lmk_le <= ~le_window;
      end
   end

endmodule

/* lmk_sequence_rom.sv */
// LMK04906 power-up sequence table with per-channel output divider selection
`include "lmk_cfg_macros.svh"

module lmk_sequence_rom
(
   input  logic [`LMK_IDX_W-1:0] index,
   input  logic [`LMK_SEL_W-1:0] freq_select,
   output lmk_cfg_pkg::lmk_entry_t entry
);
   import lmk_cfg_pkg::*;

   lmk_entry_t base;

   function automatic lmk_entry_t reg_entry(input logic [`LMK_WORD_W-1:0] word);
      lmk_entry_t e;
      e.is_delay         = 1'b0;
      e.payload.reg_word = lmk_reg_word_t'(word);
      return e;
   endfunction

   function automatic lmk_entry_t delay_entry(input logic [`LMK_WORD_W-1:0] len);
      lmk_entry_t e;
      e.is_delay            = 1'b1;
      e.payload.delay_count = len;
      return e;
   endfunction

   //////////////////////////////////////////////////
   // base map, all four FMC outputs at 322.265625 MHz

   always_comb
   begin
      case (index)
         0, 2, 4, 29: base = delay_entry(`LMK_WORD_W'(`LMK_PAUSE_LEN));
         1:  base = reg_entry(32'h8016_0200);   // reset
         3:  base = reg_entry(32'h2014_0100);   // FMCA divider
         5:  base = reg_entry(32'h1014_0101);   // FMCB divider
         6:  base = reg_entry(32'hA014_0082);
         7:  base = reg_entry(32'h0014_0103);   // FMCC divider
         8:  base = reg_entry(32'h0014_0104);   // FMCD divider
         9:  base = reg_entry(32'h8014_0C85);
         10: base = reg_entry(32'h0114_0006);
         11: base = reg_entry(32'h0111_0007);
         12: base = reg_entry(32'h0001_0008);
         13: base = reg_entry(32'h5555_5549);
         14: base = reg_entry(32'h9002_410A);
         15: base = reg_entry(32'h3401_100B);
         16: base = reg_entry(32'h130C_006C);
         17: base = reg_entry(32'h3B02_820D);
         18: base = reg_entry(32'h0200_000E);
         19: base = reg_entry(32'h8000_800F);
         20: base = reg_entry(32'hC155_0410);
         21: base = reg_entry(32'h0000_00D8);
         22: base = reg_entry(32'h02C9_C419);   // PLL2 settings
         23: base = reg_entry(32'h8FA8_001A);
         24: base = reg_entry(32'h1000_0F3B);
         25: base = reg_entry(32'h0080_031C);
         26: base = reg_entry(32'h0080_227D);
         27: base = reg_entry(32'h0300_227E);
         28: base = reg_entry(32'h001F_001F);
         default: base = delay_entry('0);       // past the end, zero-length pause
      endcase
   end

   //////////////////////////////////////////////////
   // 644.53125 MHz divider words, one select bit each

   always_comb
   begin
      entry = base;
      case (index)
         3: if (freq_select[3]) entry = reg_entry(32'h2014_0080);
         5: if (freq_select[2]) entry = reg_entry(32'h1014_0081);
         7: if (freq_select[1]) entry = reg_entry(32'h0014_0083);
         8: if (freq_select[0]) entry = reg_entry(32'h0014_0084);
         default: entry = base;
      endcase
   end

endmodule

/* bit_tick_gen.sv */
// bit-period divider issuing rise and fall strobes for the serial bus
`include "lmk_cfg_macros.svh"

module bit_tick_gen
(
   input  logic clk50,
   input  logic rst_n,
   output logic bit_rise,
   output logic bit_fall
);

   localparam int CNT_W = $clog2(`LMK_SPI_DIV);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`LMK_SPI_DIV - 1);
   localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(`LMK_SPI_DIV / 2 - 1);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge clk50 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt <= '0;
      end
      else if (cnt == CNT_LAST)
      begin
         cnt <= '0;
      end
      else
      begin
         cnt <= cnt + 1'b1;
      end
   end

   // one clk50 pulse each, half a bit period apart
   assign bit_rise = (cnt == CNT_MID);    // opens the high half of lmk_clk
   assign bit_fall = (cnt == CNT_LAST);   // period end

endmodule

/* lmk_cfg_pkg.sv */
// LMK04906 configurator sequence entry and sequencer state types
`include "lmk_cfg_macros.svh"

package lmk_cfg_pkg;

   // device write format
   typedef struct packed
   {
      logic [`LMK_WORD_W-`LMK_ADDR_W-1:0] data;
      logic [`LMK_ADDR_W-1:0]             addr;
   } lmk_reg_word_t;

   // one payload word read two ways, picked by is_delay
   typedef union packed
   {
      logic [`LMK_WORD_W-1:0] delay_count;    // pause length in bit periods
      lmk_reg_word_t          reg_word;       // word sent on the bus
   } lmk_payload_u;

   typedef struct packed
   {
      logic         is_delay;
      lmk_payload_u payload;
   } lmk_entry_t;

   typedef enum logic [1:0]
   {
      fetch,
      pause,
      send,
      advance
   } seq_state_t;

endpackage

/* lmk_cfg_macros.svh */
// LMK04906 configurator widths, sequence size and serial frame timing
`ifndef LMK_CFG_MACROS_SVH
`define LMK_CFG_MACROS_SVH

//////////////////////////////////////////////////
// widths

`define LMK_SEL_W        4     // one select bit per FMC channel
`define LMK_WORD_W       32
`define LMK_ADDR_W       5     // register address in the low bits of a word
`define LMK_IDX_W        6

//////////////////////////////////////////////////
// sequence table

`define LMK_LUT_SIZE     30
`define LMK_PAUSE_LEN    25000 // bit periods per power-up pause

//////////////////////////////////////////////////
// serial frame, in bit periods from frame start

`define LMK_SPI_DIV      4     // clk50 cycles per bit period
`define LMK_T_LE_START   1
`define LMK_T_CLK_START  2
`define LMK_T_CLK_END    33
`define LMK_T_LE_END     34
`define LMK_T_FRAME_END  37

`endif
